// File: design/bank_settings.svh
`ifndef BANK_SETTINGS_SVH
`define BANK_SETTINGS_SVH

// direct-mapped geometry
`define BANK_SETS       8
`define BANK_SET_W      3

// tag is address bits 31..7
`define BANK_TAG_W      25

`define BANK_LINE_W     128

// write data parked per requester buffer id
`define BANK_WBUF_DEPTH 8
`define BANK_WBUF_ID_W  3

`endif

// File: design/bank_pkg.sv
`default_nettype none

`include "bank_settings.svh"

package bank_pkg;

  typedef enum logic {
    OP_RD = 1'b0,
    OP_WR = 1'b1
  } req_op_e;

  // operations issued from the htu to the sram controller
  typedef enum logic [1:0] {
    SC_READ  = 2'd0,
    SC_WRITE = 2'd1,
    SC_FILL  = 2'd2,
    SC_EVICT = 2'd3
  } bank_op_e;

  typedef logic [`BANK_LINE_W-1:0] line_t;

  typedef logic [`BANK_TAG_W-1:0] tag_t;

  typedef logic [31:4] line_addr_t; // byte offset within the line dropped

endpackage

`default_nettype wire

// File: design/bank_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

interface bank_op_if;
  import bank_pkg::*;

  logic                       valid;
  logic                       ready;
  bank_op_e                   kind;
  logic [`BANK_SET_W-1:0]     set;
  logic [1:0]                 ch_id;
  logic [`BANK_WBUF_ID_W-1:0] wbuf_id;

  modport htu (output valid, kind, set, ch_id, wbuf_id, input ready);
  modport sc  (input valid, kind, set, ch_id, wbuf_id, output ready);
endinterface

interface bank_mem_if;
  import bank_pkg::*;

  logic       rd_req;    // one-cycle pulse
  logic       wr_req;    // one-cycle pulse
  line_addr_t addr;
  line_t      fill_data; // stable until the next fill
  logic       done;

  modport htu (output rd_req, wr_req, addr, input done);
  modport biu (input rd_req, wr_req, addr, output fill_data, done);
  modport sc  (input fill_data);
endinterface

`default_nettype wire

// File: design/bank_wbuffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

module bank_wbuffer (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        wr_req_i,
  input  wire [`BANK_WBUF_ID_W-1:0]  wr_id_i,
  input  wire bank_pkg::line_t       wdata_i,
  input  wire                        rd_req_i,
  input  wire [`BANK_WBUF_ID_W-1:0]  rd_id_i,
  output logic                       rd_valid_o,
  output bank_pkg::line_t            rd_data_o
);
  import bank_pkg::*;

  line_t buf_q [`BANK_WBUF_DEPTH];

  always_ff @(posedge clk_i) begin
    if (wr_req_i) buf_q[wr_id_i] <= wdata_i;  // filled at kickoff
    if (rd_req_i) rd_data_o <= buf_q[rd_id_i];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rd_valid_o <= 1'b0;
    else          rd_valid_o <= rd_req_i;      // one-cycle return
  end

endmodule

`default_nettype wire

// File: design/bank_htu.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

module bank_htu (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        xbar_bank_htu_valid_i,
  output logic                       xbar_bank_htu_allowIn_o,
  input  wire [1:0]                  xbar_bank_htu_ch_id_i,
  input  wire bank_pkg::req_op_e     xbar_bank_htu_opcode_i,
  input  wire bank_pkg::line_addr_t  xbar_bank_htu_addr_i,
  input  wire [`BANK_WBUF_ID_W-1:0]  xbar_bank_htu_wbuffer_id_i,
  bank_op_if.htu                     op,
  bank_mem_if.htu                    mem
);
  import bank_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE, S_LOOKUP, S_EVICT, S_WB, S_WB_WAIT, S_RD, S_RD_WAIT, S_FILL, S_ACCESS
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  tag_t                       tag_q [`BANK_SETS];
  logic [`BANK_SETS-1:0]      valid_q;
  logic [`BANK_SETS-1:0]      dirty_q;
  logic [1:0]                 ch_id_q;
  req_op_e                    opcode_q;
  line_addr_t                 addr_q;
  logic [`BANK_WBUF_ID_W-1:0] wbuf_id_q;
  logic [`BANK_SET_W-1:0]     set;
  tag_t                       tag;
  logic                       kickoff;
  logic                       hit;
  logic                       xfer;

  assign set     = addr_q[`BANK_SET_W+3:4];
  assign tag     = addr_q[31:`BANK_SET_W+4];
  assign hit     = valid_q[set] && (tag_q[set] == tag);
  assign xfer    = op.valid && op.ready;
  assign kickoff = xbar_bank_htu_valid_i && xbar_bank_htu_allowIn_o;

  assign xbar_bank_htu_allowIn_o = (state_q == S_IDLE);

  always_ff @(posedge clk_i) begin
    if (kickoff) begin
      ch_id_q   <= xbar_bank_htu_ch_id_i;
      opcode_q  <= xbar_bank_htu_opcode_i;
      addr_q    <= xbar_bank_htu_addr_i;
      wbuf_id_q <= xbar_bank_htu_wbuffer_id_i;
    end
    if (xfer && op.kind == SC_FILL) tag_q[set] <= tag;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      if (xfer && op.kind == SC_FILL) begin
        valid_q[set] <= 1'b1;
        dirty_q[set] <= 1'b0;
      end else if (xfer && op.kind == SC_WRITE) begin
        dirty_q[set] <= 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (kickoff) state_d = S_LOOKUP;
      S_LOOKUP: begin
        if (hit)                                state_d = S_ACCESS;
        else if (valid_q[set] && dirty_q[set])  state_d = S_EVICT;
        else                                    state_d = S_RD;
      end
      S_EVICT:   if (xfer) state_d = S_WB;
      S_WB:      state_d = S_WB_WAIT;
      S_WB_WAIT: if (mem.done) state_d = S_RD;
      S_RD:      state_d = S_RD_WAIT;
      S_RD_WAIT: if (mem.done) state_d = S_FILL;
      S_FILL:    if (xfer) state_d = S_ACCESS;
      S_ACCESS:  if (xfer) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_comb begin
    op.valid = 1'b0;
    op.kind  = SC_READ;
    case (state_q)
      S_EVICT: begin
        op.valid = 1'b1;
        op.kind  = SC_EVICT;
      end
      S_FILL: begin
        op.valid = 1'b1;
        op.kind  = SC_FILL;
      end
      S_ACCESS: begin
        op.valid = 1'b1;
        op.kind  = (opcode_q == OP_WR) ? SC_WRITE : SC_READ;
      end
      default: ;
    endcase
  end

  assign op.set     = set;
  assign op.ch_id   = ch_id_q;
  assign op.wbuf_id = wbuf_id_q;

  assign mem.rd_req = (state_q == S_RD);
  assign mem.wr_req = (state_q == S_WB);
  assign mem.addr   = (state_q == S_WB) ? {tag_q[set], set} : addr_q; // victim on write-back

endmodule

`default_nettype wire

// File: design/bank_biu.sv
`default_nettype none
`timescale 1ns/1ps

module bank_biu (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  bank_mem_if.biu               mem,
  output logic                  biu_axi3_arvalid_o,
  input  wire                   biu_axi3_arready_i,
  output logic [31:0]           biu_axi3_araddr_o,
  input  wire                   biu_axi3_rvalid_i,
  output logic                  biu_axi3_rready_o,
  input  wire bank_pkg::line_t  biu_axi3_rdata_i,
  output logic                  biu_axi3_awvalid_o,
  input  wire                   biu_axi3_awready_i,
  output logic [31:0]           biu_axi3_awaddr_o,
  output logic                  biu_axi3_wvalid_o,
  input  wire                   biu_axi3_wready_i,
  input  wire                   biu_axi3_bvalid_i,
  output logic                  biu_axi3_bready_o
);

  logic rd_done_q;
  logic wr_done_q;
  logic wb_busy_q;

  assign mem.done = rd_done_q || wr_done_q;

  // b only after both aw and w have gone out
  assign biu_axi3_bready_o = wb_busy_q && !biu_axi3_awvalid_o && !biu_axi3_wvalid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      biu_axi3_arvalid_o <= 1'b0;
      biu_axi3_rready_o  <= 1'b0;
      rd_done_q          <= 1'b0;
    end else begin
      rd_done_q <= biu_axi3_rvalid_i && biu_axi3_rready_o;
      if (mem.rd_req)              biu_axi3_arvalid_o <= 1'b1;
      else if (biu_axi3_arready_i) biu_axi3_arvalid_o <= 1'b0;
      if (biu_axi3_arvalid_o && biu_axi3_arready_i) biu_axi3_rready_o <= 1'b1;
      else if (biu_axi3_rvalid_i)                   biu_axi3_rready_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      biu_axi3_awvalid_o <= 1'b0;
      biu_axi3_wvalid_o  <= 1'b0;
      wb_busy_q          <= 1'b0;
      wr_done_q          <= 1'b0;
    end else begin
      wr_done_q <= biu_axi3_bvalid_i && biu_axi3_bready_o;
      if (mem.wr_req) begin
        biu_axi3_awvalid_o <= 1'b1;
        biu_axi3_wvalid_o  <= 1'b1;
        wb_busy_q          <= 1'b1;
      end else begin
        if (biu_axi3_awready_i) biu_axi3_awvalid_o <= 1'b0;
        if (biu_axi3_wready_i)  biu_axi3_wvalid_o  <= 1'b0;
        if (biu_axi3_bvalid_i && biu_axi3_bready_o) wb_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.rd_req) biu_axi3_araddr_o <= {mem.addr, 4'h0};
    if (mem.wr_req) biu_axi3_awaddr_o <= {mem.addr, 4'h0};
    if (biu_axi3_rvalid_i && biu_axi3_rready_o) mem.fill_data <= biu_axi3_rdata_i;
  end

endmodule

`default_nettype wire

// File: design/bank_sram_controller.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

module bank_sram_controller (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  bank_op_if.sc                      op,
  bank_mem_if.sc                     mem,
  output logic                       wbuf_rd_req_o,
  output logic [`BANK_WBUF_ID_W-1:0] wbuf_rd_id_o,
  input  wire                        wbuf_rd_valid_i,
  input  wire bank_pkg::line_t       wbuf_rd_data_i,
  output bank_pkg::line_t            evict_data_o,
  output logic                       sc_xbar_valid_o,
  input  wire                        sc_xbar_allowIn_i,
  output logic [1:0]                 sc_xbar_ch_id_o,
  output bank_pkg::line_t            sc_xbar_data_o
);
  import bank_pkg::*;

  line_t                  data_q [`BANK_SETS];
  logic [`BANK_SET_W-1:0] wr_set_q;
  logic                   wr_pend_q;
  logic                   accept;

  // stall while the write data is in flight or a response is stuck
  assign op.ready = !wr_pend_q && (!sc_xbar_valid_o || sc_xbar_allowIn_i);
  assign accept   = op.valid && op.ready;

  assign wbuf_rd_req_o = accept && (op.kind == SC_WRITE);
  assign wbuf_rd_id_o  = op.wbuf_id;

  always_ff @(posedge clk_i) begin
    if (wbuf_rd_valid_i) data_q[wr_set_q] <= wbuf_rd_data_i;
    if (accept) begin
      case (op.kind)
        SC_FILL:  data_q[op.set] <= mem.fill_data;
        SC_EVICT: evict_data_o <= data_q[op.set];
        SC_WRITE: wr_set_q <= op.set;
        SC_READ: begin
          sc_xbar_data_o  <= data_q[op.set];
          sc_xbar_ch_id_o <= op.ch_id;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_pend_q       <= 1'b0;
      sc_xbar_valid_o <= 1'b0;
    end else begin
      if (wbuf_rd_valid_i)                      wr_pend_q <= 1'b0;
      else if (accept && op.kind == SC_WRITE)   wr_pend_q <= 1'b1;
      if (accept && op.kind == SC_READ)         sc_xbar_valid_o <= 1'b1;
      else if (sc_xbar_allowIn_i)               sc_xbar_valid_o <= 1'b0; // taken by xbar
    end
  end

endmodule

`default_nettype wire

// File: design/bank_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

module bank_top (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  input  wire                        xbar_bank_htu_valid_i,
  output logic                       xbar_bank_htu_allowIn_o,
  input  wire [1:0]                  xbar_bank_htu_ch_id_i,
  input  wire bank_pkg::req_op_e     xbar_bank_htu_opcode_i,
  input  wire bank_pkg::line_addr_t  xbar_bank_htu_addr_i,
  input  wire bank_pkg::line_t       xbar_bank_htu_data_i,
  input  wire [`BANK_WBUF_ID_W-1:0]  xbar_bank_htu_wbuffer_id_i,
  output logic                       bank_sc_xbar_valid_o,
  input  wire                        bank_sc_xbar_allowIn_i,
  output logic [1:0]                 bank_sc_xbar_ch_id_o,
  output bank_pkg::line_t            bank_sc_xbar_data_o,
  output logic                       biu_axi3_arvalid_o,
  input  wire                        biu_axi3_arready_i,
  output logic [31:0]                biu_axi3_araddr_o,
  input  wire                        biu_axi3_rvalid_i,
  output logic                       biu_axi3_rready_o,
  input  wire bank_pkg::line_t       biu_axi3_rdata_i,
  output logic                       biu_axi3_awvalid_o,
  input  wire                        biu_axi3_awready_i,
  output logic [31:0]                biu_axi3_awaddr_o,
  output logic                       biu_axi3_wvalid_o,
  input  wire                        biu_axi3_wready_i,
  output bank_pkg::line_t            biu_axi3_wdata_o,
  input  wire                        biu_axi3_bvalid_i,
  output logic                       biu_axi3_bready_o
);
  import bank_pkg::*;

  logic                       wbuf_wr_req;
  logic                       wbuf_rd_req;
  logic [`BANK_WBUF_ID_W-1:0] wbuf_rd_id;
  logic                       wbuf_rd_valid;
  line_t                      wbuf_rd_data;

  bank_op_if  op_if ();
  bank_mem_if mem_if ();

  // park write data at kickoff
  assign wbuf_wr_req = xbar_bank_htu_valid_i && xbar_bank_htu_allowIn_o &&
                       (xbar_bank_htu_opcode_i == OP_WR);

  bank_htu i_htu (
    .clk_i                      (clk_i),
    .rst_n_i                    (rst_n_i),
    .xbar_bank_htu_valid_i      (xbar_bank_htu_valid_i),
    .xbar_bank_htu_allowIn_o    (xbar_bank_htu_allowIn_o),
    .xbar_bank_htu_ch_id_i      (xbar_bank_htu_ch_id_i),
    .xbar_bank_htu_opcode_i     (xbar_bank_htu_opcode_i),
    .xbar_bank_htu_addr_i       (xbar_bank_htu_addr_i),
    .xbar_bank_htu_wbuffer_id_i (xbar_bank_htu_wbuffer_id_i),
    .op                         (op_if),
    .mem                        (mem_if)
  );

  bank_wbuffer i_wbuffer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_req_i   (wbuf_wr_req),
    .wr_id_i    (xbar_bank_htu_wbuffer_id_i),
    .wdata_i    (xbar_bank_htu_data_i),
    .rd_req_i   (wbuf_rd_req),
    .rd_id_i    (wbuf_rd_id),
    .rd_valid_o (wbuf_rd_valid),
    .rd_data_o  (wbuf_rd_data)
  );

  bank_sram_controller i_sc (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .op                (op_if),
    .mem               (mem_if),
    .wbuf_rd_req_o     (wbuf_rd_req),
    .wbuf_rd_id_o      (wbuf_rd_id),
    .wbuf_rd_valid_i   (wbuf_rd_valid),
    .wbuf_rd_data_i    (wbuf_rd_data),
    .evict_data_o      (biu_axi3_wdata_o),
    .sc_xbar_valid_o   (bank_sc_xbar_valid_o),
    .sc_xbar_allowIn_i (bank_sc_xbar_allowIn_i),
    .sc_xbar_ch_id_o   (bank_sc_xbar_ch_id_o),
    .sc_xbar_data_o    (bank_sc_xbar_data_o)
  );

  bank_biu i_biu (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .mem                (mem_if),
    .biu_axi3_arvalid_o (biu_axi3_arvalid_o),
    .biu_axi3_arready_i (biu_axi3_arready_i),
    .biu_axi3_araddr_o  (biu_axi3_araddr_o),
    .biu_axi3_rvalid_i  (biu_axi3_rvalid_i),
    .biu_axi3_rready_o  (biu_axi3_rready_o),
    .biu_axi3_rdata_i   (biu_axi3_rdata_i),
    .biu_axi3_awvalid_o (biu_axi3_awvalid_o),
    .biu_axi3_awready_i (biu_axi3_awready_i),
    .biu_axi3_awaddr_o  (biu_axi3_awaddr_o),
    .biu_axi3_wvalid_o  (biu_axi3_wvalid_o),
    .biu_axi3_wready_i  (biu_axi3_wready_i),
    .biu_axi3_bvalid_i  (biu_axi3_bvalid_i),
    .biu_axi3_bready_o  (biu_axi3_bready_o)
  );

endmodule

`default_nettype wire

// File: dv/bank_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module bank_asserts (
  input wire                  clk_i,
  input wire                  rst_n_i,
  input wire                  xbar_valid_i,
  input wire                  xbar_allowIn_i,
  input wire [1:0]            xbar_ch_id_i,
  input wire bank_pkg::line_t xbar_data_i,
  input wire                  arvalid_i,
  input wire                  arready_i,
  input wire                  awvalid_i,
  input wire                  awready_i
);

  int fail_count = 0;

  // response parked under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xbar_valid_i && !xbar_allowIn_i |=>
      xbar_valid_i && $stable(xbar_data_i) && $stable(xbar_ch_id_i))
    else begin
      fail_count++;
      $error("xbar response changed before allowIn");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else begin
      fail_count++;
      $error("arvalid dropped before arready");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else begin
      fail_count++;
      $error("awvalid dropped before awready");
    end

  assert property (@(posedge clk_i) !rst_n_i |=> !xbar_valid_i)
    else begin
      fail_count++;
      $error("xbar valid high during reset");
    end

endmodule

bind bank_top bank_asserts i_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .xbar_valid_i   (bank_sc_xbar_valid_o),
  .xbar_allowIn_i (bank_sc_xbar_allowIn_i),
  .xbar_ch_id_i   (bank_sc_xbar_ch_id_o),
  .xbar_data_i    (bank_sc_xbar_data_o),
  .arvalid_i      (biu_axi3_arvalid_o),
  .arready_i      (biu_axi3_arready_i),
  .awvalid_i      (biu_axi3_awvalid_o),
  .awready_i      (biu_axi3_awready_i)
);

`default_nettype wire

// File: dv/bank_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "bank_settings.svh"

module bank_tb;
  import bank_pkg::*;

  localparam int DIRECTED_OPS   = 12;
  localparam int RAND_OPS       = 50;
  localparam int OP_CYCLES      = 32; // evict, write-back and fill against the slowest memory
  localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RAND_OPS) * OP_CYCLES;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       xbar_bank_htu_valid_i;
  logic                       xbar_bank_htu_allowIn_o;
  logic [1:0]                 xbar_bank_htu_ch_id_i;
  req_op_e                    xbar_bank_htu_opcode_i;
  line_addr_t                 xbar_bank_htu_addr_i;
  line_t                      xbar_bank_htu_data_i;
  logic [`BANK_WBUF_ID_W-1:0] xbar_bank_htu_wbuffer_id_i;
  logic                       bank_sc_xbar_valid_o;
  logic                       bank_sc_xbar_allowIn_i;
  logic [1:0]                 bank_sc_xbar_ch_id_o;
  line_t                      bank_sc_xbar_data_o;
  logic                       biu_axi3_arvalid_o;
  logic                       biu_axi3_arready_i;
  logic [31:0]                biu_axi3_araddr_o;
  logic                       biu_axi3_rvalid_i;
  logic                       biu_axi3_rready_o;
  line_t                      biu_axi3_rdata_i;
  logic                       biu_axi3_awvalid_o;
  logic                       biu_axi3_awready_i;
  logic [31:0]                biu_axi3_awaddr_o;
  logic                       biu_axi3_wvalid_o;
  logic                       biu_axi3_wready_i;
  line_t                      biu_axi3_wdata_o;
  logic                       biu_axi3_bvalid_i;
  logic                       biu_axi3_bready_o;

  line_t      mem_q [line_addr_t]; // backing memory, only lines written back
  line_t      ref_q [line_addr_t]; // last value written per line
  int         errors;
  int         tests_run;
  int         tests_failed;
  int         ar_count;
  int         aw_count;
  int         txn_seq;
  int         ar_seq;
  int         aw_seq;
  line_addr_t last_ar;
  line_addr_t last_aw;
  line_t      last_wdata;

  bank_top i_bank_top (.*);

  always #20 clk_i = ~clk_i;

  function automatic line_t default_line(line_addr_t a);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[i*32 +: 32] = ({a, i[3:0]} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    end
    return l;
  endfunction

  function automatic line_t expected_line(line_addr_t a);
    if (ref_q.exists(a)) return ref_q[a];
    return default_line(a);
  endfunction

  function automatic line_addr_t make_addr(tag_t t, logic [`BANK_SET_W-1:0] s);
    return {t, s};
  endfunction

  function automatic line_t random_line();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic log_error(string msg);
    errors++;
    $display("Fail at time %0d ns: %s", $time, msg);
  endtask

  task automatic finish_test(string name, int err0);
    tests_run++;
    if (errors == err0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err0);
    end
  endtask

  // one read transaction, address then data
  task automatic serve_read();
    int unsigned wait_n;
    line_addr_t  a;
    @(negedge clk_i);
    if (biu_axi3_arvalid_o !== 1'b1) return;
    wait_n = $urandom_range(3, 0);
    @(posedge clk_i);
    #2;
    repeat (wait_n) begin
      @(posedge clk_i);
      #2;
    end
    biu_axi3_arready_i = 1'b1;
    @(negedge clk_i);
    a = biu_axi3_araddr_o[31:4];
    ar_count++;
    txn_seq++;
    ar_seq  = txn_seq;
    last_ar = a;
    @(posedge clk_i);
    #2;
    biu_axi3_arready_i = 1'b0;
    wait_n = $urandom_range(3, 0);
    repeat (wait_n) begin
      @(posedge clk_i);
      #2;
    end
    biu_axi3_rvalid_i = 1'b1;
    biu_axi3_rdata_i  = mem_q.exists(a) ? mem_q[a] : default_line(a);
    do @(negedge clk_i); while (biu_axi3_rready_o !== 1'b1);
    @(posedge clk_i);
    #2;
    biu_axi3_rvalid_i = 1'b0;
  endtask

  // aw and w accepted independently, b once both are in
  task automatic serve_write();
    int unsigned aw_wait;
    int unsigned w_wait;
    int unsigned b_wait;
    logic        aw_done;
    logic        w_done;
    line_addr_t  a;
    line_t       d;
    @(negedge clk_i);
    if (biu_axi3_awvalid_o !== 1'b1) return;
    aw_wait = $urandom_range(3, 0);
    w_wait  = $urandom_range(3, 0);
    aw_done = 1'b0;
    w_done  = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      #2;
      biu_axi3_awready_i = !aw_done && (aw_wait == 0);
      biu_axi3_wready_i  = !w_done && (w_wait == 0);
      if (aw_wait != 0) aw_wait--;
      if (w_wait != 0) w_wait--;
      @(negedge clk_i);
      if (biu_axi3_awvalid_o && biu_axi3_awready_i) begin
        a       = biu_axi3_awaddr_o[31:4];
        aw_done = 1'b1;
      end
      if (biu_axi3_wvalid_o && biu_axi3_wready_i) begin
        d      = biu_axi3_wdata_o;
        w_done = 1'b1;
      end
    end
    @(posedge clk_i);
    #2;
    biu_axi3_awready_i = 1'b0;
    biu_axi3_wready_i  = 1'b0;
    b_wait = $urandom_range(3, 0);
    repeat (b_wait) begin
      @(posedge clk_i);
      #2;
    end
    biu_axi3_bvalid_i = 1'b1;
    do @(negedge clk_i); while (biu_axi3_bready_o !== 1'b1);
    mem_q[a] = d;
    aw_count++;
    txn_seq++;
    aw_seq     = txn_seq;
    last_aw    = a;
    last_wdata = d;
    @(posedge clk_i);
    #2;
    biu_axi3_bvalid_i = 1'b0;
  endtask

  task automatic send_req(req_op_e op, line_addr_t a, line_t d, logic [1:0] ch,
                          logic [`BANK_WBUF_ID_W-1:0] id);
    @(posedge clk_i);
    #2;
    xbar_bank_htu_valid_i      = 1'b1;
    xbar_bank_htu_opcode_i     = op;
    xbar_bank_htu_addr_i       = a;
    xbar_bank_htu_data_i       = d;
    xbar_bank_htu_ch_id_i      = ch;
    xbar_bank_htu_wbuffer_id_i = id;
    do @(negedge clk_i); while (xbar_bank_htu_allowIn_o !== 1'b1);
    @(posedge clk_i); // kickoff
    #2;
    xbar_bank_htu_valid_i = 1'b0;
  endtask

  task automatic wait_response(output line_t d, output logic [1:0] ch_o);
    do @(negedge clk_i); while (bank_sc_xbar_valid_o !== 1'b1);
    d    = bank_sc_xbar_data_o;
    ch_o = bank_sc_xbar_ch_id_o;
  endtask

  task automatic read_line(line_addr_t a, logic [1:0] ch, output line_t d,
                           output logic [1:0] ch_o);
    send_req(OP_RD, a, '0, ch, '0);
    wait_response(d, ch_o);
  endtask

  // a write is finished once the bank takes requests again
  task automatic write_line(line_addr_t a, line_t d, logic [`BANK_WBUF_ID_W-1:0] id);
    send_req(OP_WR, a, d, 2'd0, id);
    ref_q[a] = d;
    do @(negedge clk_i); while (xbar_bank_htu_allowIn_o !== 1'b1);
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk_i);
    if (xbar_bank_htu_allowIn_o !== 1'b1) log_error("allowIn_o not high after reset");
    if (bank_sc_xbar_valid_o !== 1'b0) log_error("xbar response valid after reset");
    if (biu_axi3_arvalid_o !== 1'b0 || biu_axi3_awvalid_o !== 1'b0 ||
        biu_axi3_wvalid_o !== 1'b0) begin
      log_error("AXI valid asserted after reset");
    end
    finish_test("reset state", err0);
  endtask

  task automatic test_read_miss();
    int         err0;
    int         ar0;
    line_addr_t a;
    line_t      got;
    logic [1:0] ch;
    err0 = errors;
    ar0  = ar_count;
    a    = make_addr(25'h012_345, 3'd1);
    read_line(a, 2'd2, got, ch);
    if (ar_count != ar0 + 1) log_error($sformatf("%0d AR for one miss", ar_count - ar0));
    if (last_ar !== a) log_error($sformatf("AR address %h, expected %h", last_ar, a));
    if (got !== expected_line(a)) log_error($sformatf("read data %h", got));
    if (ch !== 2'd2) log_error($sformatf("response ch_id %0d, expected 2", ch));
    finish_test("read miss", err0);
  endtask

  task automatic test_write_then_read();
    int         err0;
    int         ar0;
    int         aw0;
    line_addr_t a;
    line_t      d;
    line_t      got;
    logic [1:0] ch;
    err0 = errors;
    a    = make_addr(25'h000_abc, 3'd2);
    d    = random_line();
    ar0  = ar_count;
    write_line(a, d, 3'd5);
    if (ar_count != ar0 + 1) log_error("write miss did not fill once");
    ar0 = ar_count;
    aw0 = aw_count;
    read_line(a, 2'd1, got, ch);
    if (ar_count != ar0 || aw_count != aw0) log_error("AXI traffic on a read hit");
    if (got !== d) log_error($sformatf("read data %h, expected %h", got, d));
    finish_test("write then read", err0);
  endtask

  task automatic test_dirty_eviction();
    int         err0;
    int         ar0;
    int         aw0;
    line_addr_t a;
    line_addr_t b;
    line_t      d;
    line_t      got;
    logic [1:0] ch;
    err0 = errors;
    a    = make_addr(25'h000_100, 3'd3);
    b    = make_addr(25'h000_200, 3'd3);
    d    = random_line();
    write_line(a, d, 3'd1);
    ar0 = ar_count;
    aw0 = aw_count;
    read_line(b, 2'd3, got, ch);
    if (aw_count != aw0 + 1) log_error("dirty victim not written back once");
    if (last_aw !== a) log_error($sformatf("write-back address %h, expected %h", last_aw, a));
    if (last_wdata !== d) log_error($sformatf("write-back data %h, expected %h", last_wdata, d));
    if (ar_count != ar0 + 1 || last_ar !== b) log_error("fill of the new line missing");
    if (aw_seq > ar_seq) log_error("fill went out before the write-back");
    if (got !== expected_line(b)) log_error($sformatf("read data %h", got));
    read_line(a, 2'd0, got, ch);
    if (got !== d) log_error($sformatf("evicted line read %h, expected %h", got, d));
    finish_test("dirty eviction", err0);
  endtask

  task automatic test_backpressure();
    int          err0;
    int unsigned hold;
    line_addr_t  a;
    line_t       first;
    logic [1:0]  first_ch;
    err0 = errors;
    a    = make_addr(25'h000_abc, 3'd2);
    hold = $urandom_range(6, 2);
    @(posedge clk_i);
    #2;
    bank_sc_xbar_allowIn_i = 1'b0;
    send_req(OP_RD, a, '0, 2'd3, '0);
    wait_response(first, first_ch);
    send_req(OP_RD, a, '0, 2'd1, '0); // queued behind the held response
    repeat (hold) begin
      @(negedge clk_i);
      if (bank_sc_xbar_valid_o !== 1'b1) log_error("response dropped under back-pressure");
      if (bank_sc_xbar_data_o !== first || bank_sc_xbar_ch_id_o !== first_ch) begin
        log_error("response changed under back-pressure");
      end
      if (xbar_bank_htu_allowIn_o !== 1'b0) begin
        log_error("allowIn_o high while the response is held");
      end
    end
    @(posedge clk_i);
    #2;
    bank_sc_xbar_allowIn_i = 1'b1;
    @(negedge clk_i); // taken on the next edge
    @(negedge clk_i);
    if (bank_sc_xbar_valid_o !== 1'b1 || bank_sc_xbar_ch_id_o !== 2'd1) begin
      log_error("second response missing after the first was taken");
    end
    if (bank_sc_xbar_data_o !== expected_line(a)) begin
      log_error($sformatf("second read data %h", bank_sc_xbar_data_o));
    end
    @(negedge clk_i);
    if (bank_sc_xbar_valid_o !== 1'b0) log_error("response still valid after allowIn");
    if (xbar_bank_htu_allowIn_o !== 1'b1) log_error("allowIn_o low after the response was taken");
    if (first !== expected_line(a)) log_error($sformatf("read data %h", first));
    if (first_ch !== 2'd3) log_error($sformatf("response ch_id %0d, expected 3", first_ch));
    finish_test("back-pressure", err0);
  endtask

  // 2 tags over all 8 sets
  task automatic test_random_mix();
    int          err0;
    logic [31:0] r;
    line_addr_t  a;
    line_t       got;
    logic [1:0]  ch;
    err0 = errors;
    for (int n = 0; n < RAND_OPS; n++) begin
      r = $urandom();
      a = make_addr({24'h00_0180, r[3]}, r[2:0]);
      if (r[4]) begin
        write_line(a, random_line(), r[7:5]);
      end else begin
        read_line(a, r[9:8], got, ch);
        if (got !== expected_line(a)) begin
          log_error($sformatf("line %h read %h, expected %h", a, got, expected_line(a)));
        end
        if (ch !== r[9:8]) log_error($sformatf("response ch_id %0d, expected %0d", ch, r[9:8]));
      end
    end
    finish_test("random mix", err0);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(67439));
    clk_i                      = 1'b0;
    rst_n_i                    = 1'b0;
    xbar_bank_htu_valid_i      = 1'b0;
    xbar_bank_htu_ch_id_i      = 2'd0;
    xbar_bank_htu_opcode_i     = OP_RD;
    xbar_bank_htu_addr_i       = '0;
    xbar_bank_htu_data_i       = '0;
    xbar_bank_htu_wbuffer_id_i = '0;
    bank_sc_xbar_allowIn_i     = 1'b1;
    biu_axi3_arready_i         = 1'b0;
    biu_axi3_rvalid_i          = 1'b0;
    biu_axi3_rdata_i           = '0;
    biu_axi3_awready_i         = 1'b0;
    biu_axi3_wready_i          = 1'b0;
    biu_axi3_bvalid_i          = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    ar_count     = 0;
    aw_count     = 0;
    txn_seq      = 0;
    ar_seq       = 0;
    aw_seq       = 0;
    // memory model, read and write channels
    fork
      forever serve_read();
      forever serve_write();
    join_none
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset_state();
    test_read_miss();
    test_write_then_read();
    test_dirty_eviction();
    test_backpressure();
    test_random_mix();
    $display("tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d", tests_run,
             tests_failed, errors, i_bank_top.i_asserts.fail_count);
    if (errors == 0 && i_bank_top.i_asserts.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/bank_pkg.sv
design/bank_if.sv
design/bank_wbuffer.sv
design/bank_htu.sv
design/bank_biu.sv
design/bank_sram_controller.sv
design/bank_top.sv
dv/bank_asserts.sv
dv/bank_tb.sv

// File: Makefile
TOP := bank_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
